// ==== hdl/pc_settings.svh ====
`ifndef PC_SETTINGS_SVH
`define PC_SETTINGS_SVH

//////////////////////////////
// host link widths
//////////////////////////////

// one word from the host PC, valid/ack framed
`define PC_WORD_W 32

// payload carried by register and channel words
`define PC_CONF_W 16

//////////////////////////////
// configuration space
//////////////////////////////

// 6-bit array_id addresses the whole register file
`define PC_NREG 64

// configuration channels, picked by array_id modulo this count
`define PC_NCHAN 2

// a channel joins two PC_CONF_W transmissions into one of these
`define PC_CHAN_OUT_W 32

`endif

// ==== hdl/pc_pkg.sv ====
`include "pc_settings.svh"

package pc_pkg;

  //////////////////////////////
  // host word layout
  //////////////////////////////

  // MSB                                   LSB
  //   1          1         6       8     16
  // [ fpga_or_bd | reg_or_chan | array_id | unused | data ]
  //
  // fpga_or_bd low means the whole word is chip-bound
  // then bits 29:24 carry the leaf code and 23:0 the payload
  typedef struct packed {
    logic                                fpga_or_bd;
    logic                                reg_or_chan;
    logic [5:0]                          array_id;
    logic [`PC_WORD_W-`PC_CONF_W-9:0]    unused;
    logic [`PC_CONF_W-1:0]               data;
  } pc_word_t;

  // what the parser does with a word
  typedef enum logic [1:0] {
    BD_WORD,
    REG_WORD,
    CHAN_WORD
  } word_kind_e;

  // low half first, then high half, then hold for the consumer
  typedef enum logic [1:0] {
    WAIT_LOW,
    WAIT_HIGH,
    HOLD
  } deser_state_e;

  // chip-bound word, top two host bits dropped
  typedef struct packed {
    logic [5:0]              leaf_code;
    logic [`PC_WORD_W-9:0]   payload;
  } bd_word_t;

  // whole register file as one vector, register 0 in the low bits
  typedef logic [`PC_NREG-1:0][`PC_CONF_W-1:0] conf_regs_t;

  // joined channel value, high transmission in the upper half
  typedef logic [`PC_CHAN_OUT_W-1:0] chan_word_t;

  // reset image of the register file
  // register i comes up as 0x0100 + i
  function automatic conf_regs_t build_reset_table();
    conf_regs_t table_out;
    for (int i = 0; i < `PC_NREG; i++) begin
      table_out[i] = `PC_CONF_W'(16'h0100 + i);
    end
    return table_out;
  endfunction

  localparam conf_regs_t reg_reset_table = build_reset_table();

endpackage

// ==== hdl/input_staller.sv ====
`timescale 1ns/100ps

module input_staller (
  // host side
  input  logic            in_valid,
  input  pc_pkg::pc_word_t in_data,
  output logic            in_ack,

  // parser side
  output logic            out_valid,
  output pc_pkg::pc_word_t out_data,
  input  logic            out_ack,

  // level from the traffic manager
  input  logic            stall
);

  //////////////////////////////
  // handshake masking
  //////////////////////////////

  // the word itself is untouched, only the framing is gated
  assign out_data = in_data;

  // parser sees nothing while stalled
  assign out_valid = in_valid & ~stall;

  // and the host never sees an ack, so it keeps holding the word
  assign in_ack = out_ack & ~stall;

  //////////////////////////////
  // checks
  //////////////////////////////

  // no transfer may complete on either side during a stall
  always_comb begin
    if (stall) begin
      assert (!out_valid && !(in_valid && in_ack))
        else $error("input_staller: handshake passed while stalled");
    end
  end

endmodule

// ==== hdl/pc_parser.sv ====
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_parser (
  input  logic                                  clk,
  input  logic                                  reset,

  // host words, already stall-masked
  input  logic                                  in_valid,
  input  pc_pkg::pc_word_t                      in_data,
  output logic                                  in_ack,

  // register file image
  output pc_pkg::conf_regs_t                    conf_regs,

  // chip-bound passthrough
  output logic                                  bd_valid,
  output pc_pkg::bd_word_t                      bd_data,
  input  logic                                  bd_ack,

  // one 16-bit stream per configuration channel
  output logic [`PC_NCHAN-1:0]                  cfg_valid,
  output logic [`PC_NCHAN-1:0][`PC_CONF_W-1:0]  cfg_data,
  input  logic [`PC_NCHAN-1:0]                  cfg_ack
);

  localparam int REG_ADDR_W = $clog2(`PC_NREG);
  localparam int CHAN_SEL_W = $clog2(`PC_NCHAN);

  pc_pkg::word_kind_e     kind;
  logic [REG_ADDR_W-1:0]  reg_addr;
  logic [CHAN_SEL_W-1:0]  chan_sel;
  logic                   reg_write;

  //////////////////////////////
  // decode
  //////////////////////////////

  // top bit separates chip traffic from fpga traffic
  // next bit picks register vs channel
  always_comb begin
    if (!in_data.fpga_or_bd) begin
      kind = pc_pkg::BD_WORD;
    end else if (!in_data.reg_or_chan) begin
      kind = pc_pkg::REG_WORD;
    end else begin
      kind = pc_pkg::CHAN_WORD;
    end
  end

  // low bits of array_id address the register file or pick a channel
  assign reg_addr = in_data.array_id[REG_ADDR_W-1:0];
  assign chan_sel = in_data.array_id[CHAN_SEL_W-1:0];

  //////////////////////////////
  // register file
  //////////////////////////////

  // register words never wait, so valid alone is a transfer
  assign reg_write = in_valid && (kind == pc_pkg::REG_WORD);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      conf_regs <= pc_pkg::reg_reset_table;
    end else if (reg_write) begin
      conf_regs[reg_addr] <= in_data.data;
    end
  end

  //////////////////////////////
  // bd passthrough
  //////////////////////////////

  // leaf code sits where array_id is for fpga words
  // payload is everything below it
  assign bd_valid          = in_valid && (kind == pc_pkg::BD_WORD);
  assign bd_data.leaf_code = in_data.array_id;
  assign bd_data.payload   = {in_data.unused, in_data.data};

  //////////////////////////////
  // channel steering
  //////////////////////////////

  // every channel sees the same data, only the addressed one gets valid
  always_comb begin
    for (int i = 0; i < `PC_NCHAN; i++) begin
      cfg_valid[i] = in_valid && (kind == pc_pkg::CHAN_WORD) &&
                     (chan_sel == CHAN_SEL_W'(i));
      cfg_data[i]  = in_data.data;
    end
  end

  //////////////////////////////
  // host ack
  //////////////////////////////

  // ack comes straight from whichever destination was picked
  always_comb begin
    in_ack = 1'b0;
    if (in_valid) begin
      unique case (kind)
        pc_pkg::BD_WORD:   in_ack = bd_ack;
        pc_pkg::REG_WORD:  in_ack = 1'b1;
        pc_pkg::CHAN_WORD: in_ack = cfg_ack[chan_sel];
        default:           in_ack = 1'b0;
      endcase
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // a word goes to at most one channel
  cfg_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(cfg_valid)
  ) else $error("pc_parser: more than one cfg_valid");

  // and never to a channel and the chip at once
  bd_cfg_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(bd_valid && |cfg_valid)
  ) else $error("pc_parser: bd and cfg valid together");

endmodule

// ==== hdl/chan_deserializer.sv ====
`timescale 1ns/100ps
`include "pc_settings.svh"

module chan_deserializer (
  input  logic                   clk,
  input  logic                   reset,

  // 16-bit stream from the parser
  input  logic                   cfg_valid,
  input  logic [`PC_CONF_W-1:0]  cfg_data,
  output logic                   cfg_ack,

  // joined word to the consumer
  output logic                   chan_valid,
  output pc_pkg::chan_word_t     chan_data,
  input  logic                   chan_ack
);

  pc_pkg::deser_state_e   state;
  logic [`PC_CONF_W-1:0]  low_half;

  //////////////////////////////
  // handshake
  //////////////////////////////

  // accept halves until a full word is waiting, then push back
  assign cfg_ack    = (state != pc_pkg::HOLD);
  assign chan_valid = (state == pc_pkg::HOLD);

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= pc_pkg::WAIT_LOW;
    end else begin
      case (state)
        pc_pkg::WAIT_LOW: begin
          if (cfg_valid) begin
            state <= pc_pkg::WAIT_HIGH;
          end
        end
        pc_pkg::WAIT_HIGH: begin
          if (cfg_valid) begin
            state <= pc_pkg::HOLD;
          end
        end
        pc_pkg::HOLD: begin
          // consumer took it, start over with a fresh low half
          if (chan_ack) begin
            state <= pc_pkg::WAIT_LOW;
          end
        end
        default: begin
          state <= pc_pkg::WAIT_LOW;
        end
      endcase
    end
  end

  //////////////////////////////
  // data path
  //////////////////////////////

  // halves only load while ack is high, so valid marks a transfer
  always_ff @(posedge clk) begin
    if (state == pc_pkg::WAIT_LOW && cfg_valid) begin
      low_half <= cfg_data;
    end
    if (state == pc_pkg::WAIT_HIGH && cfg_valid) begin
      chan_data <= {cfg_data, low_half};
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // once offered, the word stays put until taken
  hold_stable: assert property (
    @(posedge clk) disable iff (reset)
    chan_valid && !chan_ack |=> chan_valid && $stable(chan_data)
  ) else $error("chan_deserializer: output changed before ack");

endmodule

// ==== hdl/pc_config_top.sv ====
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_config_top (
  input  logic                                clk,
  input  logic                                reset,

  // host link
  input  logic                                pc_valid,
  input  pc_pkg::pc_word_t                    pc_data,
  output logic                                pc_ack,

  // back-pressure from the traffic manager
  input  logic                                stall,

  // chip-bound words
  output logic                                bd_valid,
  output pc_pkg::bd_word_t                    bd_data,
  input  logic                                bd_ack,

  // deserialized configuration channels
  output logic [`PC_NCHAN-1:0]                chan_valid,
  output pc_pkg::chan_word_t [`PC_NCHAN-1:0]  chan_data,
  input  logic [`PC_NCHAN-1:0]                chan_ack,

  // register file
  output pc_pkg::conf_regs_t                  conf_regs
);

  // host channel after stall masking
  logic                                  staged_valid;
  pc_pkg::pc_word_t                      staged_data;
  logic                                  staged_ack;

  // parser to deserializer streams
  logic [`PC_NCHAN-1:0]                  cfg_valid;
  logic [`PC_NCHAN-1:0][`PC_CONF_W-1:0]  cfg_data;
  logic [`PC_NCHAN-1:0]                  cfg_ack;

  //////////////////////////////
  // input side
  //////////////////////////////

  input_staller u_staller (
    .in_valid  (pc_valid),
    .in_data   (pc_data),
    .in_ack    (pc_ack),
    .out_valid (staged_valid),
    .out_data  (staged_data),
    .out_ack   (staged_ack),
    .stall     (stall)
  );

  pc_parser u_parser (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (staged_valid),
    .in_data   (staged_data),
    .in_ack    (staged_ack),
    .conf_regs (conf_regs),
    .bd_valid  (bd_valid),
    .bd_data   (bd_data),
    .bd_ack    (bd_ack),
    .cfg_valid (cfg_valid),
    .cfg_data  (cfg_data),
    .cfg_ack   (cfg_ack)
  );

  //////////////////////////////
  // one deserializer per channel
  //////////////////////////////

  for (genvar i = 0; i < `PC_NCHAN; i++) begin : g_chan
    chan_deserializer u_deser (
      .clk        (clk),
      .reset      (reset),
      .cfg_valid  (cfg_valid[i]),
      .cfg_data   (cfg_data[i]),
      .cfg_ack    (cfg_ack[i]),
      .chan_valid (chan_valid[i]),
      .chan_data  (chan_data[i]),
      .chan_ack   (chan_ack[i])
    );
  end

endmodule

// ==== tests/pc_config_tb.sv ====
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_config_tb;

  typedef logic [8*24-1:0] tname_t;
  typedef logic [8*8-1:0]  tkind_t;

  logic                                clk;
  logic                                reset;
  logic                                pc_valid;
  pc_pkg::pc_word_t                    pc_data;
  logic                                pc_ack;
  logic                                stall;
  logic                                bd_valid;
  pc_pkg::bd_word_t                    bd_data;
  logic                                bd_ack;
  logic [`PC_NCHAN-1:0]                chan_valid;
  pc_pkg::chan_word_t [`PC_NCHAN-1:0]  chan_data;
  logic [`PC_NCHAN-1:0]                chan_ack;
  pc_pkg::conf_regs_t                  conf_regs;

  // vectors as read from the data file
  tname_t       vec_name[$];
  tkind_t       vec_kind[$];
  logic [31:0]  vec_word[$];
  logic [31:0]  vec_exp[$];
  int           n_vec;

  // expected register file, plus which channels hold a lone low half
  pc_pkg::conf_regs_t    reg_model;
  logic [`PC_NCHAN-1:0]  half_seen;
  int                    seed;

  pc_config_top uut (.*);

  always #2 clk = ~clk;

  //////////////////////////////
  // reporting and compares
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "test run stopped");
  endtask

  task automatic check_flag(input tname_t name, input string what,
                            input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %0s %0s expected %b actual %b", name, what, exp, act));
    end
  endtask

  // first differing register is enough to locate the fault
  task automatic check_regs(input tname_t name, input pc_pkg::conf_regs_t exp,
                            input pc_pkg::conf_regs_t act);
    for (int i = 0; i < `PC_NREG; i++) begin
      if (act[i] !== exp[i]) begin
        abort_run($sformatf("mismatch %0s reg %0d expected %h actual %h",
                            name, i, exp[i], act[i]));
      end
    end
  endtask

  task automatic check_bd(input tname_t name, input pc_pkg::bd_word_t exp,
                          input pc_pkg::bd_word_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %0s bd_data expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_chan(input tname_t name, input pc_pkg::chan_word_t exp,
                            input pc_pkg::chan_word_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %0s chan_data expected %h actual %h", name, exp, act));
    end
  endtask

  // register i comes out of reset as 0x0100 + i
  function automatic pc_pkg::conf_regs_t reset_image();
    pc_pkg::conf_regs_t img;
    for (int i = 0; i < `PC_NREG; i++) begin
      img[i] = 16'h0100 + 16'(i);
    end
    return img;
  endfunction

  //////////////////////////////
  // stimulus steps
  //////////////////////////////

  // drive point just after the edge, downstream acks re-rolled every cycle
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #0.5;
    r = $random(seed);
    bd_ack   = r[0];
    chan_ack = r[2:1];
  endtask

  task automatic do_reg(input tname_t name, input pc_pkg::pc_word_t w, input logic [31:0] exp);
    pc_valid = 1'b1;
    pc_data  = w;
    stall    = 1'b0;
    @(negedge clk);
    // register words never wait
    check_flag(name, "pc_ack", 1'b1, pc_ack);
    check_flag(name, "bd_valid", 1'b0, bd_valid);
    reg_model[w.array_id] = exp[15:0];
    next_cycle();
    pc_valid = 1'b0;
    @(negedge clk);
    check_regs(name, reg_model, conf_regs);
    next_cycle();
  endtask

  task automatic do_bd(input tname_t name, input pc_pkg::pc_word_t w, input logic [31:0] exp);
    logic done;
    done     = 1'b0;
    pc_valid = 1'b1;
    pc_data  = w;
    stall    = 1'b0;
    while (!done) begin
      @(negedge clk);
      check_flag(name, "bd_valid", 1'b1, bd_valid);
      check_bd(name, exp[29:0], bd_data);
      // host only sees an ack in the cycle the chip side takes it
      check_flag(name, "pc_ack", bd_ack, pc_ack);
      done = bd_ack;
      next_cycle();
    end
    pc_valid = 1'b0;
  endtask

  task automatic do_chan(input tname_t name, input pc_pkg::pc_word_t w, input logic [31:0] exp);
    logic ch;
    logic done;
    ch       = w.array_id[0];
    done     = 1'b0;
    pc_valid = 1'b1;
    pc_data  = w;
    stall    = 1'b0;
    @(negedge clk);
    check_flag(name, "pc_ack", 1'b1, pc_ack);
    check_flag(name, "chan_valid early", 1'b0, chan_valid[ch]);
    next_cycle();
    pc_valid = 1'b0;
    if (!half_seen[ch]) begin
      // low half only, nothing leaves the channel yet
      half_seen[ch] = 1'b1;
    end else begin
      half_seen[ch] = 1'b0;
      // joined word must sit there under random acks
      while (!done) begin
        @(negedge clk);
        check_flag(name, "chan_valid", 1'b1, chan_valid[ch]);
        check_flag(name, "other chan_valid", 1'b0, chan_valid[~ch]);
        check_chan(name, exp, chan_data[ch]);
        done = chan_ack[ch];
        next_cycle();
      end
      // taken once, so it has to be gone now
      @(negedge clk);
      check_flag(name, "chan_valid after ack", 1'b0, chan_valid[ch]);
      next_cycle();
    end
  endtask

  task automatic do_stall(input tname_t name, input pc_pkg::pc_word_t w, input logic [31:0] exp);
    pc_valid = 1'b1;
    pc_data  = w;
    stall    = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_flag(name, "pc_ack under stall", 1'b0, pc_ack);
      check_flag(name, "bd_valid under stall", 1'b0, bd_valid);
      check_flag(name, "chan_valid under stall", 1'b0, |chan_valid);
      check_regs(name, reg_model, conf_regs);
      next_cycle();
    end
    // stall released, the held word goes through by its own kind
    if (!w.fpga_or_bd) begin
      do_bd(name, w, exp);
    end else if (!w.reg_or_chan) begin
      do_reg(name, w, exp);
    end else begin
      do_chan(name, w, exp);
    end
  endtask

  task automatic do_reset(input tname_t name);
    pc_valid = 1'b0;
    stall    = 1'b0;
    reset    = 1'b1;
    repeat (4) next_cycle();
    reset     = 1'b0;
    reg_model = reset_image();
    half_seen = '0;
    @(negedge clk);
    check_regs(name, reg_model, conf_regs);
    check_flag(name, "bd_valid", 1'b0, bd_valid);
    check_flag(name, "chan_valid", 1'b0, |chan_valid);
    check_flag(name, "pc_ack", 1'b0, pc_ack);
    next_cycle();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int                fd;
    int                cnt;
    tname_t            nm;
    tkind_t            kd;
    logic [31:0]       wd;
    logic [31:0]       ex;
    logic [8*128-1:0]  line;
    clk       = 1'b0;
    reset     = 1'b1;
    pc_valid  = 1'b0;
    pc_data   = '0;
    stall     = 1'b0;
    bd_ack    = 1'b0;
    chan_ack  = '0;
    seed      = 32'h13dc9c68;
    reg_model = reset_image();
    half_seen = '0;
    fd = $fopen("tests/pc_config_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tests/pc_config_tests.txt");
    end
    forever begin
      line = '0;
      if ($fgets(line, fd) == 0) break;
      cnt = $sscanf(line, "%s %s %h %h", nm, kd, wd, ex);
      // comment and blank lines never give four fields
      if (cnt == 4 && nm != tname_t'("//")) begin
        vec_name.push_back(nm);
        vec_kind.push_back(kd);
        vec_word.push_back(wd);
        vec_exp.push_back(ex);
      end
    end
    $fclose(fd);
    n_vec = vec_name.size();
    if (n_vec == 0) begin
      abort_run("no test vectors found in tests/pc_config_tests.txt");
    end
    do_reset(tname_t'("power_on"));
    for (int k = 0; k < n_vec; k++) begin
      case (vec_kind[k])
        tkind_t'("REG"):      do_reg(vec_name[k], vec_word[k], vec_exp[k]);
        tkind_t'("BD"):       do_bd(vec_name[k], vec_word[k], vec_exp[k]);
        tkind_t'("CHAN"):     do_chan(vec_name[k], vec_word[k], vec_exp[k]);
        tkind_t'("STALL"):    do_stall(vec_name[k], vec_word[k], vec_exp[k]);
        tkind_t'("RESETCHK"): do_reset(vec_name[k]);
        default: abort_run($sformatf("unknown kind %0s in test %0s", vec_kind[k], vec_name[k]));
      endcase
    end
    if (half_seen == '0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("a channel still holds an unpaired low half at the end of the vectors");
    end
  end

  // budget of 200 cycles per vector line
  initial begin
    wait (n_vec != 0);
    repeat (n_vec * 200) @(posedge clk);
    abort_run($sformatf("run timed out after %0d cycles", n_vec * 200));
  end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/pc_pkg.sv
hdl/input_staller.sv
hdl/pc_parser.sv
hdl/chan_deserializer.sv
hdl/pc_config_top.sv
tests/pc_config_tb.sv

// ==== Makefile ====
# Verilator flow for the configuration front end testbench
# run from the project root so the vector file path resolves

compile:
	verilator --binary --timing --assert --top-module pc_config_tb -f files.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vpc_config_tb)"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: compile run clean

// ==== tests/pc_config_tests.txt ====
// name kind input_word expected_value, both words in hex
// kinds REG BD CHAN STALL RESETCHK, a CHAN pair carries the joined value on both lines
reset_first      RESETCHK 00000000 00000000
reg_05           REG      85001234 00001234
reg_3f           REG      BF00BEEF 0000BEEF
reg_00           REG      8000A5A5 0000A5A5
reg_20_unused    REG      A0FF0042 00000042
reg_05_again     REG      85117777 00007777
bd_leaf_1a       BD       1A123456 1A123456
bd_bit30_set     BD       7F00FFFF 3F00FFFF
bd_leaf_00       BD       40ABCDEF 00ABCDEF
bd_leaf_2c       BD       2C000001 2C000001
chan0_low        CHAN     C2001111 22221111
chan0_high       CHAN     C2002222 22221111
chan1_low        CHAN     C300AAAA BBBBAAAA
chan1_high       CHAN     C300BBBB BBBBAAAA
mix_ch1_low      CHAN     C5001357 9ABC1357
mix_ch0_low      CHAN     C8002468 FEDC2468
mix_ch1_high     CHAN     C5009ABC 9ABC1357
mix_ch0_high     CHAN     C800FEDC FEDC2468
stall_reg        STALL    8A00CAFE 0000CAFE
stall_bd         STALL    15000ABC 15000ABC
stall_chan_low   CHAN     C7000123 04560123
stall_chan_high  STALL    C7000456 04560123
reset_again      RESETCHK 00000000 00000000
reg_after_reset  REG      BF000001 00000001
